//--- common/seq_pkg.sv
`default_nettype none

package seq_pkg;

    // Instruction word and program space
    localparam int WORD_W    = 16;
    localparam int ROM_DEPTH = 4096;
    localparam string ROM_FILE = "sim/program.hex";

    // Targets of r_field in load instructions
    localparam logic [2:0] R_PT = 3'd0;
    localparam logic [2:0] R_PR = 3'd1;
    localparam logic [2:0] R_PI = 3'd2;
    localparam logic [2:0] R_I  = 3'd3;

    // Instruction classes from bits 15:12
    typedef enum logic [3:0] {
        op_nop      = 4'h0,
        op_goto     = 4'h1,
        op_call     = 4'h2,
        op_goto_b   = 4'h3,
        op_icall    = 4'h4,
        op_load_imm = 4'h5,
        op_load_acc = 4'h6,
        op_pt_read  = 4'h7,
        op_do       = 4'h8
    } op_t;

    // Register branch kinds from bits 11:10
    typedef enum logic [1:0] {
        br_ret     = 2'd0,
        br_iret    = 2'd1,
        br_goto_pt = 2'd2,
        br_call_pt = 2'd3
    } br_t;

    typedef struct packed {
        op_t         op;
        logic [2:0]  r_field;
        br_t         bsel;
        logic        istep;
        logic [8:0]  imm;
        logic [11:0] target;
        logic [3:0]  do_n;
        logic [3:0]  do_k;
    } ctl_t;

    typedef struct packed {
        logic [15:0] pc;
        logic [15:0] pr;
        logic [15:0] pi;
        logic [15:0] pt;
        logic [11:0] i;
        logic        shadow;
    } regs_t;

endpackage

`default_nettype wire

//--- hdl/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction word to control strobes, purely combinational
module insn_decode (
    input  logic [15:0]   instr,
    output seq_pkg::ctl_t ctl
);
    import seq_pkg::*;

    always_comb begin
        ctl = '0;

        // Opcode field, anything unlisted runs as a nop
        case (instr[15:12])
            op_goto: begin
                ctl.op = op_goto;
            end
            op_call: begin
                ctl.op = op_call;
            end
            op_goto_b: begin
                ctl.op = op_goto_b;
            end
            op_icall: begin
                ctl.op = op_icall;
            end
            op_load_imm: begin
                ctl.op = op_load_imm;
            end
            op_load_acc: begin
                ctl.op = op_load_acc;
            end
            op_pt_read: begin
                ctl.op = op_pt_read;
            end
            op_do: begin
                ctl.op = op_do;
            end
            default: begin
                ctl.op = op_nop;
            end
        endcase

        // Operand fields only for the classes that read them
        case (ctl.op)
            op_goto, op_call: begin
                ctl.target = instr[11:0];
            end
            op_goto_b: begin
                ctl.bsel = br_t'(instr[11:10]);
            end
            op_load_imm: begin
                ctl.r_field = instr[11:9];
                ctl.imm     = instr[8:0];
            end
            op_load_acc: begin
                ctl.r_field = instr[11:9];
            end
            op_pt_read: begin
                // Bit 8 selects the step by i instead of by one
                ctl.istep = instr[8];
            end
            op_do: begin
                ctl.do_n = instr[7:4];
                ctl.do_k = instr[3:0];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rom_aau/do_loop.sv
`timescale 1ns/1ps
`default_nettype none

// Do loop counter: records the first pass, then replays the body
module do_loop (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        start,
    input  logic [3:0]  body_len,
    input  logic [3:0]  passes,
    input  logic [15:0] pc,
    output logic        loop_active,
    output logic [15:0] replay_addr,
    output logic        loop_done
);

    logic        recording;
    logic [3:0]  pos;
    logic [3:0]  left;     // replay passes still to run
    logic [15:0] head;
    logic [3:0]  last_pos;
    logic        at_end;

    assign at_end      = pos == last_pos;
    assign replay_addr = head + {12'd0, pos};

    // End of recording with no replays, or last replay position
    assign loop_done = cen && at_end &&
                       ((recording && left == 4'd0) || (loop_active && left == 4'd1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            recording   <= 1'b0;
            loop_active <= 1'b0;
            pos         <= 4'd0;
            left        <= 4'd0;
        end else if (cen) begin
            if (start) begin
                recording   <= 1'b1;
                loop_active <= 1'b0;
                pos         <= 4'd0;
                left        <= passes - 4'd1;
            end else if (recording || loop_active) begin
                if (at_end) begin
                    pos       <= 4'd0;
                    recording <= 1'b0;
                    if (recording) begin
                        loop_active <= left != 4'd0;
                    end else begin
                        left        <= left - 4'd1;
                        loop_active <= left != 4'd1;
                    end
                end else begin
                    pos <= pos + 4'd1;
                end
            end
        end
    end

    // Body starts right after the do instruction
    always_ff @(posedge clk) begin
        if (cen && start) begin
            head     <= pc + 16'd1;
            last_pos <= body_len - 4'd1;
        end
    end

endmodule

`default_nettype wire

//--- rom_aau/rom_aau.sv
`timescale 1ns/1ps
`default_nettype none

// ROM address arithmetic unit
module rom_aau (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           ext_irq,
    input  seq_pkg::ctl_t  ctl,
    input  logic [15:0]    acc_in,
    output logic [11:0]    rom_addr,
    output logic [11:0]    pt_addr,
    output logic           pt_strobe,
    output logic           iack,
    output seq_pkg::regs_t regs
);
    import seq_pkg::*;

    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] pr;
    logic [WORD_W-1:0] pi;
    logic [WORD_W-1:0] pt;
    logic [11:0]       i;
    logic              shadow;

    logic [WORD_W-1:0] seq_pc;
    logic [WORD_W-1:0] i_ext;
    logic [WORD_W-1:0] load_val;
    logic [WORD_W-1:0] next_pc;
    logic [WORD_W-1:0] replay_addr;
    logic              loop_active;
    logic              loop_done;
    logic              enter_int;
    logic              exec;
    logic              branch;
    logic              is_load;
    logic              is_iret;
    logic              reg_jump;
    logic              call_save;
    logic              do_start;

    assign seq_pc = pc + 16'd1;
    assign i_ext  = {{(WORD_W - 12){i[11]}}, i};

    // Interrupt replaces the fetched instruction
    assign enter_int = ext_irq && shadow && !loop_active;
    assign exec      = !enter_int;
    // Replayed bodies keep pc, so no flow changes there
    assign branch    = exec && !loop_active;

    assign is_load   = exec && (ctl.op == op_load_imm || ctl.op == op_load_acc);
    assign load_val  = (ctl.op == op_load_acc) ? acc_in : {7'd0, ctl.imm};
    assign is_iret   = branch && ctl.op == op_goto_b && ctl.bsel == br_iret;
    assign reg_jump  = branch && ctl.op == op_goto_b;
    assign call_save = branch && (ctl.op == op_call ||
                       (ctl.op == op_goto_b && ctl.bsel == br_call_pt));
    assign do_start  = branch && ctl.op == op_do && ctl.do_n != 4'd0 && ctl.do_k != 4'd0;

    assign rom_addr  = loop_active ? replay_addr[11:0] : pc[11:0];
    assign pt_addr   = pt[11:0];
    assign pt_strobe = exec && ctl.op == op_pt_read;

    always_comb begin
        regs.pc     = pc;
        regs.pr     = pr;
        regs.pi     = pi;
        regs.pt     = pt;
        regs.i      = i;
        regs.shadow = shadow;
    end

    // Next pc, highest priority first
    always_comb begin
        if (loop_active) begin
            next_pc = pc;
        end else if (enter_int) begin
            next_pc = 16'd1;
        end else if (ctl.op == op_icall) begin
            next_pc = 16'd2;
        end else if (ctl.op == op_goto || ctl.op == op_call) begin
            next_pc = {pc[WORD_W-1:12], ctl.target};
        end else if (reg_jump) begin
            case (ctl.bsel)
                br_ret:  next_pc = pr;
                br_iret: next_pc = pi;
                default: next_pc = pt;
            endcase
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= '0;
            pr     <= '0;
            pi     <= '0;
            pt     <= '0;
            i      <= '0;
            shadow <= 1'b1;
            iack   <= 1'b0;
        end else if (cen) begin
            pc   <= next_pc;
            iack <= enter_int;

            if (call_save) begin
                pr <= seq_pc;
            end else if (is_load && ctl.r_field == R_PR) begin
                pr <= load_val;
            end

            // Skipped instruction address is the one to resume at
            if (enter_int) begin
                pi <= pc;
            end else if (is_load && ctl.r_field == R_PI) begin
                pi <= load_val;
            end else if (shadow) begin
                pi <= seq_pc;
            end

            if (is_load && ctl.r_field == R_PT) begin
                pt <= load_val;
            end else if (pt_strobe) begin
                pt <= pt + (ctl.istep ? i_ext : 16'd1);
            end

            if (is_load && ctl.r_field == R_I) begin
                i <= load_val[11:0];
            end

            if (enter_int || (branch && ctl.op == op_icall) || do_start) begin
                shadow <= 1'b0;
            end else if (is_iret || loop_done) begin
                shadow <= 1'b1;
            end
        end
    end

    do_loop loop_i (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .start       (do_start),
        .body_len    (ctl.do_n),
        .passes      (ctl.do_k),
        .pc          (pc),
        .loop_active (loop_active),
        .replay_addr (replay_addr),
        .loop_done   (loop_done)
    );

endmodule

`default_nettype wire

//--- hdl/program_rom.sv
`timescale 1ns/1ps
`default_nettype none

// Program memory with asynchronous read
module program_rom (
    input  logic        clk,
    input  logic [11:0] addr,
    output logic [15:0] data
);
    import seq_pkg::*;

    logic [WORD_W-1:0] mem [0:ROM_DEPTH-1];

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // Word is available in the same cycle as the address
    assign data = mem[addr];

endmodule

`default_nettype wire

//--- hdl/seq_top.sv
`timescale 1ns/1ps
`default_nettype none

// Program sequencer top level
module seq_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           ext_irq,
    input  logic [15:0]    acc_in,
    output logic [11:0]    rom_addr,
    output logic [11:0]    pt_addr,
    output logic           pt_strobe,
    output logic           iack,
    output seq_pkg::regs_t regs
);
    import seq_pkg::*;

    logic [WORD_W-1:0] instr;
    ctl_t              ctl;

    program_rom rom_i (
        .clk  (clk),
        .addr (rom_addr),
        .data (instr)
    );

    insn_decode dec_i (
        .instr (instr),
        .ctl   (ctl)
    );

    rom_aau aau_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ext_irq   (ext_irq),
        .ctl       (ctl),
        .acc_in    (acc_in),
        .rom_addr  (rom_addr),
        .pt_addr   (pt_addr),
        .pt_strobe (pt_strobe),
        .iack      (iack),
        .regs      (regs)
    );

endmodule

`default_nettype wire

//--- sim/seq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seq_tb;
    import seq_pkg::*;

    localparam int          MAX_CYCLES = 2000;
    localparam logic [11:0] HALT_ADDR  = 12'h060;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        ext_irq;
    logic [15:0] acc_in;
    logic [11:0] rom_addr;
    logic [11:0] pt_addr;
    logic        pt_strobe;
    logic        iack;
    regs_t       regs;

    // Reference model state
    logic [15:0] rom_copy [0:ROM_DEPTH-1];
    logic [15:0] m_pc;
    logic [15:0] m_pr;
    logic [15:0] m_pi;
    logic [15:0] m_pt;
    logic [11:0] m_i;
    logic        m_shadow;
    logic        m_iack;
    logic        m_rec;
    logic        m_rep;
    logic [3:0]  m_pos;
    logic [3:0]  m_n;
    logic [3:0]  m_left;
    logic [15:0] m_head;
    int          irq_count;

    logic [15:0] m_word;
    op_t         m_op;
    logic [11:0] exp_rom_addr;
    logic        exp_take_irq;
    logic        exp_pt_strobe;

    logic [31:0] rng;
    logic [2:0]  irq_armed;
    int          cycle_count;
    int          halt_cycles;

    seq_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ext_irq   (ext_irq),
        .acc_in    (acc_in),
        .rom_addr  (rom_addr),
        .pt_addr   (pt_addr),
        .pt_strobe (pt_strobe),
        .iack      (iack),
        .regs      (regs)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        $readmemh("sim/program.hex", rom_copy);
    end

    // Fetch and interrupt decision for the current cycle
    always_comb begin
        exp_rom_addr  = m_rep ? m_head[11:0] + {8'd0, m_pos} : m_pc[11:0];
        m_word        = rom_copy[exp_rom_addr];
        m_op          = (m_word[15:12] > 4'h8) ? op_nop : op_t'(m_word[15:12]);
        exp_take_irq  = ext_irq && m_shadow && !m_rep;
        exp_pt_strobe = !exp_take_irq && m_op == op_pt_read;
    end

    always @(posedge clk or posedge rst) begin : model_step
        logic [15:0] word;
        logic [15:0] next_pc;
        logic [15:0] load_val;
        logic        take;
        logic        executes;
        logic        flows;
        logic        is_load;
        logic        clr_shadow;
        logic        set_shadow;
        if (rst) begin
            m_pc = '0;
            m_pr = '0;
            m_pi = '0;
            m_pt = '0;
            m_i = '0;
            m_shadow = 1'b1;
            m_iack = 1'b0;
            m_rec = 1'b0;
            m_rep = 1'b0;
            m_pos = '0;
            m_n = '0;
            m_left = '0;
            m_head = '0;
        end else if (cen) begin
            word = m_word;
            take = exp_take_irq;
            executes = !take;
            flows = executes && !m_rep;
            is_load = executes && (m_op == op_load_imm || m_op == op_load_acc);
            load_val = (m_op == op_load_acc) ? acc_in : {7'd0, word[8:0]};
            clr_shadow = take || (flows && m_op == op_icall);
            set_shadow = flows && m_op == op_goto_b && word[11:10] == br_iret;

            if (m_rep) begin
                next_pc = m_pc;
            end else if (take) begin
                next_pc = 16'd1;
            end else if (m_op == op_icall) begin
                next_pc = 16'd2;
            end else if (m_op == op_goto || m_op == op_call) begin
                next_pc = {m_pc[15:12], word[11:0]};
            end else if (m_op == op_goto_b) begin
                case (word[11:10])
                    br_ret:  next_pc = m_pr;
                    br_iret: next_pc = m_pi;
                    default: next_pc = m_pt;
                endcase
            end else begin
                next_pc = m_pc + 16'd1;
            end

            // pi follows pc+1 only while shadow was set before this edge
            if (take) begin
                m_pi = m_pc;
            end else if (is_load && word[11:9] == R_PI) begin
                m_pi = load_val;
            end else if (m_shadow) begin
                m_pi = m_pc + 16'd1;
            end

            if (flows && (m_op == op_call ||
                          (m_op == op_goto_b && word[11:10] == br_call_pt))) begin
                m_pr = m_pc + 16'd1;
            end else if (is_load && word[11:9] == R_PR) begin
                m_pr = load_val;
            end

            if (is_load && word[11:9] == R_PT) begin
                m_pt = load_val;
            end else if (executes && m_op == op_pt_read) begin
                m_pt = m_pt + (word[8] ? {{4{m_i[11]}}, m_i} : 16'd1);
            end

            if (is_load && word[11:9] == R_I) begin
                m_i = load_val[11:0];
            end

            // First pass runs from ROM, then k-1 replays of the body
            if (flows && m_op == op_do && word[7:4] != 4'd0 && word[3:0] != 4'd0) begin
                m_rec = 1'b1;
                m_rep = 1'b0;
                m_pos = 4'd0;
                m_n = word[7:4];
                m_left = word[3:0] - 4'd1;
                m_head = m_pc + 16'd1;
                clr_shadow = 1'b1;
            end else if (m_rec || m_rep) begin
                if (m_pos == m_n - 4'd1) begin
                    m_pos = 4'd0;
                    if (!m_rec) begin
                        m_left = m_left - 4'd1;
                    end
                    m_rec = 1'b0;
                    m_rep = m_left != 4'd0;
                    if (m_left == 4'd0) begin
                        set_shadow = 1'b1;
                    end
                end else begin
                    m_pos = m_pos + 4'd1;
                end
            end

            if (clr_shadow) begin
                m_shadow = 1'b0;
            end else if (set_shadow) begin
                m_shadow = 1'b1;
            end
            m_iack = take;
            m_pc = next_pc;
        end
    end

    // Interrupts acknowledged by the DUT
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_count <= 0;
        end else if (cen && iack) begin
            irq_count <= irq_count + 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) rom_addr == exp_rom_addr)
        else report_mismatch("rom_addr", {4'd0, $sampled(exp_rom_addr)},
                             {4'd0, $sampled(rom_addr)});
    assert property (@(posedge clk) disable iff (rst) pt_strobe == exp_pt_strobe)
        else report_mismatch("pt_strobe", {15'd0, $sampled(exp_pt_strobe)},
                             {15'd0, $sampled(pt_strobe)});
    assert property (@(posedge clk) disable iff (rst) pt_addr == m_pt[11:0])
        else report_mismatch("pt_addr", {4'd0, $sampled(m_pt[11:0])}, {4'd0, $sampled(pt_addr)});
    assert property (@(posedge clk) disable iff (rst) iack == m_iack)
        else report_mismatch("iack", {15'd0, $sampled(m_iack)}, {15'd0, $sampled(iack)});
    assert property (@(posedge clk) disable iff (rst) regs.pc == m_pc)
        else report_mismatch("regs.pc", $sampled(m_pc), $sampled(regs.pc));
    assert property (@(posedge clk) disable iff (rst) regs.pr == m_pr)
        else report_mismatch("regs.pr", $sampled(m_pr), $sampled(regs.pr));
    assert property (@(posedge clk) disable iff (rst) regs.pi == m_pi)
        else report_mismatch("regs.pi", $sampled(m_pi), $sampled(regs.pi));
    assert property (@(posedge clk) disable iff (rst) regs.pt == m_pt)
        else report_mismatch("regs.pt", $sampled(m_pt), $sampled(regs.pt));
    assert property (@(posedge clk) disable iff (rst) regs.i == m_i)
        else report_mismatch("regs.i", {4'd0, $sampled(m_i)}, {4'd0, $sampled(regs.i)});
    assert property (@(posedge clk) disable iff (rst) regs.shadow == m_shadow)
        else report_mismatch("regs.shadow", {15'd0, $sampled(m_shadow)},
                             {15'd0, $sampled(regs.shadow)});

    // Run limit in clock cycles, reset included
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: halt loop not reached within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst = 1'b1;
        cen = 1'b0;
        ext_irq = 1'b0;
        acc_in = 16'h0000;
        rng = 32'd36371;
        irq_armed = '0;
        halt_cycles = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (halt_cycles < 4) begin
            @(negedge clk);
            rng = xorshift(rng);
            cen = rng[1:0] != 2'd0;

            // Interrupt requests keyed to fetch addresses and dropped on iack
            if (m_iack) begin
                ext_irq = 1'b0;
            end else if (!irq_armed[0] && exp_rom_addr == 12'h013) begin
                ext_irq = 1'b1;
                irq_armed[0] = 1'b1;
            end else if (!irq_armed[1] && m_rep && exp_rom_addr == 12'h01d) begin
                ext_irq = 1'b1;
                irq_armed[1] = 1'b1;
            end else if (!irq_armed[2] && exp_rom_addr == 12'h091) begin
                ext_irq = 1'b1;
                irq_armed[2] = 1'b1;
            end

            case (exp_rom_addr)
                12'h014: acc_in = 16'hfffe;
                12'h017: acc_in = 16'ha5c3;
                default: acc_in = 16'h5a5a;
            endcase

            if (exp_rom_addr == HALT_ADDR) begin
                halt_cycles++;
            end
        end

        if (irq_count == 3) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Only %0d of 3 expected interrupts were acknowledged", irq_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "interrupt count");
        end
    end

endmodule

`default_nettype wire

//--- sim/program.hex
// One 16-bit instruction word per line, opcode in bits 15:12
// @ lines set the word address of the words that follow
@000
1010 // reset: goto main
1080 // interrupt entry: goto isr
1090 // icall entry: goto icall handler
@010
5020 // pt = 0x020
5603 // i = 3
7000 // pt read, step 1
7100 // pt read, step i
6600 // i = acc_in
7100
5230 // pr = 0x030
6400 // pi = acc_in
2040 // call 0x040
5050 // pt = 0x050
3c00 // call through pt
8034 // do n=3 k=4
7000
7100
0000
0000
4000 // icall
0000
5060 // pt = 0x060
3800 // goto pt
@040
5601 // i = 1
3000 // return through pr
@050
0000
3000
@060
1060 // halt loop
@080
0000
3400 // return from interrupt
@090
0000
0000
3400

//--- filelist.f
common/seq_pkg.sv
hdl/insn_decode.sv
rom_aau/do_loop.sv
rom_aau/rom_aau.sv
hdl/program_rom.sv
hdl/seq_top.sv
sim/seq_tb.sv

//--- run.sh
#!/bin/sh
# Build the sequencer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module seq_tb -f filelist.f &&
./obj_dir/Vseq_tb ||
{ echo "simulation did not pass"; exit 1; }
